// File: source/isa_pkg.sv
package isa_pkg;

  //////////////////////////////
  // Major opcodes
  //////////////////////////////

  localparam logic [6:0] OPCODE_LOAD  = 7'b0000011;
  localparam logic [6:0] OPCODE_STORE = 7'b0100011;
  localparam logic [6:0] OPCODE_OPIMM = 7'b0010011;
  localparam logic [6:0] OPCODE_OP    = 7'b0110011;
  localparam logic [6:0] OPCODE_LUI   = 7'b0110111;
  localparam logic [6:0] OPCODE_AMO   = 7'b0101111;

  // funct7 values seen under OP
  localparam logic [6:0] FUNCT7_BASE   = 7'b0000000;
  localparam logic [6:0] FUNCT7_SUB    = 7'b0100000;
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

  //////////////////////////////
  // AMO funct5 codes
  //////////////////////////////

  localparam logic [4:0] AMO_LR   = 5'b00010;
  localparam logic [4:0] AMO_SC   = 5'b00011;
  localparam logic [4:0] AMO_SWAP = 5'b00001;
  localparam logic [4:0] AMO_ADD  = 5'b00000;
  localparam logic [4:0] AMO_XOR  = 5'b00100;
  localparam logic [4:0] AMO_AND  = 5'b01100;
  localparam logic [4:0] AMO_OR   = 5'b01000;
  localparam logic [4:0] AMO_MIN  = 5'b10000;
  localparam logic [4:0] AMO_MAX  = 5'b10100;
  localparam logic [4:0] AMO_MINU = 5'b11000;
  localparam logic [4:0] AMO_MAXU = 5'b11100;

  // Only word-sized atomics exist on RV32
  localparam logic [2:0] AMO_WIDTH_W = 3'b010;

  //////////////////////////////
  // Instruction word views
  //////////////////////////////

  // Register-register layout
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instr_r_t;

  // Atomic layout, funct7 split into funct5 and ordering bits
  typedef struct packed {
    logic [4:0] funct5;
    logic       aq;
    logic       rl;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instr_amo_t;

  // Same 32 bits, read whichever way the decoder needs
  typedef union packed {
    instr_r_t   r;
    instr_amo_t amo;
  } instr_u;

endpackage

// File: source/ctrl_pkg.sv
package ctrl_pkg;

  //////////////////////////////
  // Operand mux selects
  //////////////////////////////

  typedef enum logic [1:0] {
    OP_A_REGA_OR_FWD = 2'b00,
    OP_A_CURRPC      = 2'b01,
    OP_A_IMM         = 2'b10
  } op_a_sel_e;

  typedef enum logic [1:0] {
    OP_B_REGB_OR_FWD = 2'b00,
    OP_B_IMM         = 2'b01,
    OP_B_NONE        = 2'b10
  } op_b_sel_e;

  // Operand c carries store and AMO write data
  typedef enum logic [1:0] {
    OP_C_NONE        = 2'b00,
    OP_C_REGB_OR_FWD = 2'b01
  } op_c_sel_e;

  //////////////////////////////
  // Execute op codes
  //////////////////////////////

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9,
    ALU_LUI  = 4'd10
  } alu_op_e;

  // Encoded exactly as funct3 of the M extension
  typedef enum logic [2:0] {
    MUL_OP_MUL    = 3'd0,
    MUL_OP_MULH   = 3'd1,
    MUL_OP_MULHSU = 3'd2,
    MUL_OP_MULHU  = 3'd3,
    MUL_OP_DIV    = 3'd4,
    MUL_OP_DIVU   = 3'd5,
    MUL_OP_REM    = 3'd6,
    MUL_OP_REMU   = 3'd7
  } mul_op_e;

  //////////////////////////////
  // Decoder control word
  //////////////////////////////

  typedef struct packed {
    logic      match;
    logic      illegal_insn;
    logic      alu_en;
    alu_op_e   alu_op;
    op_a_sel_e alu_op_a_mux_sel;
    op_b_sel_e alu_op_b_mux_sel;
    op_c_sel_e alu_op_c_mux_sel;
    logic      mul_en;
    mul_op_e   mul_op;
    logic      data_req;
    logic      data_we;
    logic [1:0] data_type;
    logic      data_sign_ext;
    logic [5:0] data_atop;
    logic [1:0] rf_re;
    logic      rf_we;
    logic      prepost_useincr;
  } decoder_ctrl_t;

  // Nothing enabled, address adder left in a+imm mode
  localparam decoder_ctrl_t DECODER_CTRL_IDLE = '{
    match:            1'b0,
    illegal_insn:     1'b0,
    alu_en:           1'b0,
    alu_op:           ALU_ADD,
    alu_op_a_mux_sel: OP_A_REGA_OR_FWD,
    alu_op_b_mux_sel: OP_B_NONE,
    alu_op_c_mux_sel: OP_C_NONE,
    mul_en:           1'b0,
    mul_op:           MUL_OP_MUL,
    data_req:         1'b0,
    data_we:          1'b0,
    data_type:        2'b00,
    data_sign_ext:    1'b0,
    data_atop:        6'b000000,
    rf_re:            2'b00,
    rf_we:            1'b0,
    prepost_useincr:  1'b1
  };

endpackage

// File: source/i_decoder.sv
`timescale 1ns/1ps

module i_decoder (
  input  isa_pkg::instr_u         instr_i,
  output ctrl_pkg::decoder_ctrl_t decoder_ctrl_o
);

  import isa_pkg::*;
  import ctrl_pkg::*;

  always_comb begin
    decoder_ctrl_o = DECODER_CTRL_IDLE;

    case (instr_i.r.opcode)

      //////////////////////////////
      // Loads and stores
      //////////////////////////////

      OPCODE_LOAD: begin
        decoder_ctrl_o.match            = 1'b1;
        decoder_ctrl_o.alu_op_a_mux_sel = OP_A_REGA_OR_FWD;
        decoder_ctrl_o.alu_op_b_mux_sel = OP_B_IMM;
        decoder_ctrl_o.data_req         = 1'b1;
        // Size from funct3[1:0], funct3[2] means unsigned
        decoder_ctrl_o.data_type        = instr_i.r.funct3[1:0];
        decoder_ctrl_o.data_sign_ext    = ~instr_i.r.funct3[2];
        decoder_ctrl_o.rf_re[0]         = 1'b1;
        decoder_ctrl_o.rf_we            = 1'b1;
        // Address is rs1 + imm
        decoder_ctrl_o.prepost_useincr  = 1'b1;
        // No LD, and no unsigned word on RV32
        if ((instr_i.r.funct3[1:0] == 2'b11) || (instr_i.r.funct3 == 3'b110)) begin
          decoder_ctrl_o.illegal_insn = 1'b1;
        end
      end

      OPCODE_STORE: begin
        decoder_ctrl_o.match            = 1'b1;
        decoder_ctrl_o.alu_op_a_mux_sel = OP_A_REGA_OR_FWD;
        decoder_ctrl_o.alu_op_b_mux_sel = OP_B_IMM;
        // Store data rides on operand c
        decoder_ctrl_o.alu_op_c_mux_sel = OP_C_REGB_OR_FWD;
        decoder_ctrl_o.data_req         = 1'b1;
        decoder_ctrl_o.data_we          = 1'b1;
        decoder_ctrl_o.data_type        = instr_i.r.funct3[1:0];
        decoder_ctrl_o.rf_re            = 2'b11;
        decoder_ctrl_o.prepost_useincr  = 1'b1;
        // SB, SH and SW only
        if (instr_i.r.funct3 >= 3'd3) begin
          decoder_ctrl_o.illegal_insn = 1'b1;
        end
      end

      //////////////////////////////
      // Integer ALU
      //////////////////////////////

      OPCODE_OPIMM: begin
        decoder_ctrl_o.match            = 1'b1;
        decoder_ctrl_o.alu_en           = 1'b1;
        decoder_ctrl_o.alu_op_a_mux_sel = OP_A_REGA_OR_FWD;
        decoder_ctrl_o.alu_op_b_mux_sel = OP_B_IMM;
        decoder_ctrl_o.rf_re[0]         = 1'b1;
        decoder_ctrl_o.rf_we            = 1'b1;
        case (instr_i.r.funct3)
          3'b000: decoder_ctrl_o.alu_op = ALU_ADD;
          3'b010: decoder_ctrl_o.alu_op = ALU_SLT;
          3'b011: decoder_ctrl_o.alu_op = ALU_SLTU;
          3'b100: decoder_ctrl_o.alu_op = ALU_XOR;
          3'b110: decoder_ctrl_o.alu_op = ALU_OR;
          3'b111: decoder_ctrl_o.alu_op = ALU_AND;
          // Shift amount sits in rs2, upper bits must be clean
          3'b001: begin
            decoder_ctrl_o.alu_op = ALU_SLL;
            if (instr_i.r.funct7 != FUNCT7_BASE) begin
              decoder_ctrl_o.illegal_insn = 1'b1;
            end
          end
          default: begin
            // SRLI or SRAI picked by bit 30
            if (instr_i.r.funct7 == FUNCT7_BASE) begin
              decoder_ctrl_o.alu_op = ALU_SRL;
            end else if (instr_i.r.funct7 == FUNCT7_SUB) begin
              decoder_ctrl_o.alu_op = ALU_SRA;
            end else begin
              decoder_ctrl_o.illegal_insn = 1'b1;
            end
          end
        endcase
      end

      OPCODE_OP: begin
        // MULDIV and anything else belong elsewhere
        if ((instr_i.r.funct7 == FUNCT7_BASE) || (instr_i.r.funct7 == FUNCT7_SUB)) begin
          decoder_ctrl_o.match            = 1'b1;
          decoder_ctrl_o.alu_en           = 1'b1;
          decoder_ctrl_o.alu_op_a_mux_sel = OP_A_REGA_OR_FWD;
          decoder_ctrl_o.alu_op_b_mux_sel = OP_B_REGB_OR_FWD;
          decoder_ctrl_o.rf_re            = 2'b11;
          decoder_ctrl_o.rf_we            = 1'b1;
          case ({instr_i.r.funct7, instr_i.r.funct3})
            {FUNCT7_BASE, 3'b000}: decoder_ctrl_o.alu_op = ALU_ADD;
            {FUNCT7_SUB,  3'b000}: decoder_ctrl_o.alu_op = ALU_SUB;
            {FUNCT7_BASE, 3'b001}: decoder_ctrl_o.alu_op = ALU_SLL;
            {FUNCT7_BASE, 3'b010}: decoder_ctrl_o.alu_op = ALU_SLT;
            {FUNCT7_BASE, 3'b011}: decoder_ctrl_o.alu_op = ALU_SLTU;
            {FUNCT7_BASE, 3'b100}: decoder_ctrl_o.alu_op = ALU_XOR;
            {FUNCT7_BASE, 3'b101}: decoder_ctrl_o.alu_op = ALU_SRL;
            {FUNCT7_SUB,  3'b101}: decoder_ctrl_o.alu_op = ALU_SRA;
            {FUNCT7_BASE, 3'b110}: decoder_ctrl_o.alu_op = ALU_OR;
            {FUNCT7_BASE, 3'b111}: decoder_ctrl_o.alu_op = ALU_AND;
            // Bit 30 set on an op that has no alternate form
            default:               decoder_ctrl_o.illegal_insn = 1'b1;
          endcase
        end
      end

      OPCODE_LUI: begin
        // ALU passes the upper immediate straight through
        decoder_ctrl_o.match            = 1'b1;
        decoder_ctrl_o.alu_en           = 1'b1;
        decoder_ctrl_o.alu_op           = ALU_LUI;
        decoder_ctrl_o.alu_op_a_mux_sel = OP_A_IMM;
        decoder_ctrl_o.alu_op_b_mux_sel = OP_B_IMM;
        decoder_ctrl_o.rf_we            = 1'b1;
      end

      default: begin
        // Not ours, stay idle
      end
    endcase
  end

endmodule

// File: source/m_decoder.sv
`timescale 1ns/1ps

module m_decoder (
  input  isa_pkg::instr_u         instr_i,
  output ctrl_pkg::decoder_ctrl_t decoder_ctrl_o
);

  import isa_pkg::*;
  import ctrl_pkg::*;

  //////////////////////////////
  // RV32M multiply / divide
  //////////////////////////////

  always_comb begin
    decoder_ctrl_o = DECODER_CTRL_IDLE;

    // Only OP with the MULDIV funct7 is ours
    if ((instr_i.r.opcode == OPCODE_OP) && (instr_i.r.funct7 == FUNCT7_MULDIV)) begin
      decoder_ctrl_o.match    = 1'b1;
      decoder_ctrl_o.mul_en   = 1'b1;
      // All eight funct3 codes are defined
      decoder_ctrl_o.mul_op   = mul_op_e'(instr_i.r.funct3);
      // Both sources read, result written back
      decoder_ctrl_o.rf_re    = 2'b11;
      decoder_ctrl_o.rf_we    = 1'b1;
    end
  end

endmodule

// File: source/a_decoder.sv
`timescale 1ns/1ps

module a_decoder (
  input  isa_pkg::instr_u         instr_i,
  output ctrl_pkg::decoder_ctrl_t decoder_ctrl_o
);

  import isa_pkg::*;
  import ctrl_pkg::*;

  // Raw decode before illegal cleanup
  decoder_ctrl_t amo_ctrl;

  //////////////////////////////
  // RV32A word atomics
  //////////////////////////////

  always_comb begin
    amo_ctrl = DECODER_CTRL_IDLE;

    if (instr_i.amo.opcode == OPCODE_AMO) begin
      if (instr_i.amo.funct3 == AMO_WIDTH_W) begin
        amo_ctrl.match            = 1'b1;
        amo_ctrl.data_req         = 1'b1;
        // Word access
        amo_ctrl.data_type        = 2'b10;
        amo_ctrl.data_sign_ext    = 1'b1;
        amo_ctrl.rf_re            = 2'b11;
        amo_ctrl.rf_we            = 1'b1;
        // Address is rs1 alone, no offset
        amo_ctrl.prepost_useincr  = 1'b0;
        amo_ctrl.alu_op_a_mux_sel = OP_A_REGA_OR_FWD;
        // Top bit marks an atomic, low bits carry the operation
        amo_ctrl.data_atop        = {1'b1, instr_i.amo.funct5};

        case (instr_i.amo.funct5)
          AMO_LR: begin
            amo_ctrl.data_we = 1'b0;
          end
          AMO_SC, AMO_SWAP, AMO_ADD, AMO_XOR, AMO_AND, AMO_OR,
          AMO_MIN, AMO_MAX, AMO_MINU, AMO_MAXU: begin
            amo_ctrl.data_we          = 1'b1;
            // rs2 goes out as write data
            amo_ctrl.alu_op_c_mux_sel = OP_C_REGB_OR_FWD;
          end
          default: amo_ctrl.illegal_insn = 1'b1;
        endcase
      end else begin
        // Byte, half and double atomics do not exist here
        amo_ctrl.illegal_insn = 1'b1;
      end
    end
  end

  // Illegal result carries no partial control
  always_comb begin
    if (amo_ctrl.illegal_insn) begin
      decoder_ctrl_o              = DECODER_CTRL_IDLE;
      decoder_ctrl_o.illegal_insn = 1'b1;
    end else begin
      decoder_ctrl_o = amo_ctrl;
    end
  end

endmodule

// File: source/decoder.sv
`timescale 1ns/1ps

module decoder (
  input  isa_pkg::instr_u         instr_i,
  input  logic                    illegal_c_insn_i,
  output ctrl_pkg::decoder_ctrl_t decoder_ctrl_o
);

  import ctrl_pkg::*;

  // Per-extension results
  decoder_ctrl_t i_ctrl;
  decoder_ctrl_t m_ctrl;
  decoder_ctrl_t a_ctrl;

  // Merge helpers
  decoder_ctrl_t merged_ctrl;
  logic          any_match;
  logic          any_illegal;

  //////////////////////////////
  // Sub-decoders
  //////////////////////////////

  i_decoder i_decoder_i (
    .instr_i        (instr_i),
    .decoder_ctrl_o (i_ctrl)
  );

  m_decoder m_decoder_i (
    .instr_i        (instr_i),
    .decoder_ctrl_o (m_ctrl)
  );

  a_decoder a_decoder_i (
    .instr_i        (instr_i),
    .decoder_ctrl_o (a_ctrl)
  );

  //////////////////////////////
  // Combiner
  //////////////////////////////

  assign any_match   = i_ctrl.match | m_ctrl.match | a_ctrl.match;
  assign any_illegal = i_ctrl.illegal_insn | m_ctrl.illegal_insn | a_ctrl.illegal_insn;

  // Ownership is disjoint, so at most one word survives its own match gate
  assign merged_ctrl = decoder_ctrl_t'(
                         ({$bits(decoder_ctrl_t){i_ctrl.match}} & i_ctrl) |
                         ({$bits(decoder_ctrl_t){m_ctrl.match}} & m_ctrl) |
                         ({$bits(decoder_ctrl_t){a_ctrl.match}} & a_ctrl));

  // Any reason to reject collapses to idle plus illegal
  always_comb begin
    if (illegal_c_insn_i || any_illegal || !any_match) begin
      decoder_ctrl_o              = DECODER_CTRL_IDLE;
      decoder_ctrl_o.illegal_insn = 1'b1;
    end else begin
      decoder_ctrl_o = merged_ctrl;
    end
  end

endmodule

// File: source/id_stage.sv
`timescale 1ns/1ps

module id_stage (
  input  logic                    clk,
  input  logic                    arst_n_i,

  // From IF/ID
  input  logic                    instr_valid_i,
  input  isa_pkg::instr_u         instr_rdata_i,
  input  logic                    illegal_c_insn_i,

  // To EX
  output logic                    ctrl_valid_o,
  output ctrl_pkg::decoder_ctrl_t ctrl_o
);

  import ctrl_pkg::*;

  // Combinational decode of the current word
  decoder_ctrl_t dec_ctrl;

  //////////////////////////////
  // Decode
  //////////////////////////////

  decoder decoder_i (
    .instr_i          (instr_rdata_i),
    .illegal_c_insn_i (illegal_c_insn_i),
    .decoder_ctrl_o   (dec_ctrl)
  );

  //////////////////////////////
  // ID/EX register
  //////////////////////////////

  // Valid follows the strobe every cycle
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ctrl_valid_o <= 1'b0;
    end else begin
      ctrl_valid_o <= instr_valid_i;
    end
  end

  // Control word only moves on a valid input, otherwise holds
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ctrl_o <= DECODER_CTRL_IDLE;
    end else if (instr_valid_i) begin
      ctrl_o <= dec_ctrl;
    end
  end

endmodule

// File: test/tb_id_stage.sv
`timescale 1ns/1ps

module tb_id_stage;

  import isa_pkg::*;
  import ctrl_pkg::*;

  // Stimulus is well under this, the margin covers gaps and flushes
  localparam int STIM_CYCLES = 400;
  localparam int MAX_CYCLES  = STIM_CYCLES * 5;

  logic          clk;
  logic          arst_n_i;
  logic          instr_valid_i;
  instr_u        instr_rdata_i;
  logic          illegal_c_insn_i;
  logic          ctrl_valid_o;
  decoder_ctrl_t ctrl_o;

  // Reference pipeline register
  logic          exp_valid;
  decoder_ctrl_t exp_ctrl;

  integer seed = 28;
  int     err_count = 0;
  int     tests_run = 0;
  int     tests_failed = 0;
  int     cycle_count;

  id_stage dut_i (
    .clk              (clk),
    .arst_n_i         (arst_n_i),
    .instr_valid_i    (instr_valid_i),
    .instr_rdata_i    (instr_rdata_i),
    .illegal_c_insn_i (illegal_c_insn_i),
    .ctrl_valid_o     (ctrl_valid_o),
    .ctrl_o           (ctrl_o)
  );

  //////////////////////////////
  // Clock and watchdog
  //////////////////////////////

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < MAX_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Base ALU op per funct3, bit 30 handled by the caller
  function automatic alu_op_e alu_for_funct3(input logic [2:0] f3);
    case (f3)
      3'd0:    return ALU_ADD;
      3'd1:    return ALU_SLL;
      3'd2:    return ALU_SLT;
      3'd3:    return ALU_SLTU;
      3'd4:    return ALU_XOR;
      3'd5:    return ALU_SRL;
      3'd6:    return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  function automatic decoder_ctrl_t expected_ctrl(input instr_u w, input logic illc);
    decoder_ctrl_t c;
    logic          bad;
    logic [2:0]    f3;
    logic [6:0]    f7;
    c   = DECODER_CTRL_IDLE;
    bad = 1'b0;
    f3  = w.r.funct3;
    f7  = w.r.funct7;
    case (w.r.opcode)
      OPCODE_AMO: begin
        c.match           = 1'b1;
        c.data_req        = 1'b1;
        c.data_type       = 2'b10;
        c.data_sign_ext   = 1'b1;
        c.rf_re           = 2'b11;
        c.rf_we           = 1'b1;
        c.prepost_useincr = 1'b0;
        c.data_atop       = {1'b1, w.amo.funct5};
        if (w.amo.funct5 != AMO_LR) begin
          c.data_we          = 1'b1;
          c.alu_op_c_mux_sel = OP_C_REGB_OR_FWD;
        end
        bad = (f3 != AMO_WIDTH_W) || !(w.amo.funct5 inside {AMO_LR, AMO_SC, AMO_SWAP,
              AMO_ADD, AMO_XOR, AMO_AND, AMO_OR, AMO_MIN, AMO_MAX, AMO_MINU, AMO_MAXU});
      end
      OPCODE_LOAD: begin
        c.match            = 1'b1;
        c.alu_op_b_mux_sel = OP_B_IMM;
        c.data_req         = 1'b1;
        c.rf_re            = 2'b01;
        c.rf_we            = 1'b1;
        // LB, LH and LW sign extend, LBU and LHU zero extend
        case (f3)
          3'd0, 3'd4: c.data_type = 2'b00;
          3'd1, 3'd5: c.data_type = 2'b01;
          3'd2:       c.data_type = 2'b10;
          default:    bad = 1'b1;
        endcase
        c.data_sign_ext = (f3 inside {3'd0, 3'd1, 3'd2});
      end
      OPCODE_STORE: begin
        c.match            = 1'b1;
        c.alu_op_b_mux_sel = OP_B_IMM;
        c.alu_op_c_mux_sel = OP_C_REGB_OR_FWD;
        c.data_req         = 1'b1;
        c.data_we          = 1'b1;
        c.rf_re            = 2'b11;
        // SB, SH and SW
        case (f3)
          3'd0:    c.data_type = 2'b00;
          3'd1:    c.data_type = 2'b01;
          3'd2:    c.data_type = 2'b10;
          default: bad = 1'b1;
        endcase
      end
      OPCODE_OPIMM: begin
        c.match            = 1'b1;
        c.alu_en           = 1'b1;
        c.alu_op_b_mux_sel = OP_B_IMM;
        c.rf_re            = 2'b01;
        c.rf_we            = 1'b1;
        c.alu_op           = alu_for_funct3(f3);
        if ((f3 == 3'd1) && (f7 != FUNCT7_BASE)) begin
          bad = 1'b1;
        end
        if ((f3 == 3'd5) && (f7 == FUNCT7_SUB)) begin
          c.alu_op = ALU_SRA;
        end else if ((f3 == 3'd5) && (f7 != FUNCT7_BASE)) begin
          bad = 1'b1;
        end
      end
      OPCODE_OP: begin
        c.match = 1'b1;
        c.rf_re = 2'b11;
        c.rf_we = 1'b1;
        if (f7 == FUNCT7_MULDIV) begin
          c.mul_en = 1'b1;
          c.mul_op = mul_op_e'(f3);
        end else if ((f7 == FUNCT7_BASE) || (f7 == FUNCT7_SUB)) begin
          c.alu_en           = 1'b1;
          c.alu_op_b_mux_sel = OP_B_REGB_OR_FWD;
          c.alu_op           = alu_for_funct3(f3);
          // Only ADD and SRL have a bit-30 form
          if (f7 == FUNCT7_SUB) begin
            if (f3 == 3'd0) begin
              c.alu_op = ALU_SUB;
            end else if (f3 == 3'd5) begin
              c.alu_op = ALU_SRA;
            end else begin
              bad = 1'b1;
            end
          end
        end else begin
          bad = 1'b1;
        end
      end
      OPCODE_LUI: begin
        c.match            = 1'b1;
        c.alu_en           = 1'b1;
        c.alu_op           = ALU_LUI;
        c.alu_op_a_mux_sel = OP_A_IMM;
        c.alu_op_b_mux_sel = OP_B_IMM;
        c.rf_we            = 1'b1;
      end
      default: bad = 1'b1;
    endcase
    if (bad || illc) begin
      c              = DECODER_CTRL_IDLE;
      c.illegal_insn = 1'b1;
    end
    return c;
  endfunction

  // One edge of latency, word held while the strobe is low
  always @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exp_valid <= 1'b0;
      exp_ctrl  <= DECODER_CTRL_IDLE;
    end else begin
      exp_valid <= instr_valid_i;
      if (instr_valid_i) begin
        exp_ctrl <= expected_ctrl(instr_rdata_i, illegal_c_insn_i);
      end
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic show_field(input string name, input int unsigned got, input int unsigned exp);
    if (got != exp) begin
      $display("ERROR t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic report_ctrl_mismatch(input decoder_ctrl_t got, input decoder_ctrl_t exp);
    err_count++;
    show_field("ctrl_o.match", 32'(got.match), 32'(exp.match));
    show_field("ctrl_o.illegal_insn", 32'(got.illegal_insn), 32'(exp.illegal_insn));
    show_field("ctrl_o.alu_en", 32'(got.alu_en), 32'(exp.alu_en));
    show_field("ctrl_o.alu_op", 32'(got.alu_op), 32'(exp.alu_op));
    show_field("ctrl_o.alu_op_a_mux_sel", 32'(got.alu_op_a_mux_sel), 32'(exp.alu_op_a_mux_sel));
    show_field("ctrl_o.alu_op_b_mux_sel", 32'(got.alu_op_b_mux_sel), 32'(exp.alu_op_b_mux_sel));
    show_field("ctrl_o.alu_op_c_mux_sel", 32'(got.alu_op_c_mux_sel), 32'(exp.alu_op_c_mux_sel));
    show_field("ctrl_o.mul_en", 32'(got.mul_en), 32'(exp.mul_en));
    show_field("ctrl_o.mul_op", 32'(got.mul_op), 32'(exp.mul_op));
    show_field("ctrl_o.data_req", 32'(got.data_req), 32'(exp.data_req));
    show_field("ctrl_o.data_we", 32'(got.data_we), 32'(exp.data_we));
    show_field("ctrl_o.data_type", 32'(got.data_type), 32'(exp.data_type));
    show_field("ctrl_o.data_sign_ext", 32'(got.data_sign_ext), 32'(exp.data_sign_ext));
    show_field("ctrl_o.data_atop", 32'(got.data_atop), 32'(exp.data_atop));
    show_field("ctrl_o.rf_re", 32'(got.rf_re), 32'(exp.rf_re));
    show_field("ctrl_o.rf_we", 32'(got.rf_we), 32'(exp.rf_we));
    show_field("ctrl_o.prepost_useincr", 32'(got.prepost_useincr), 32'(exp.prepost_useincr));
  endtask

  // Sampled on the falling edge, well away from drive and capture
  valid_chk: assert property (@(negedge clk) ctrl_valid_o == exp_valid)
    else begin
      err_count++;
      show_field("ctrl_valid_o", 32'(ctrl_valid_o), 32'(exp_valid));
    end

  ctrl_chk: assert property (@(negedge clk) ctrl_o == exp_ctrl)
    else report_ctrl_mismatch(ctrl_o, exp_ctrl);

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  function automatic instr_u make_r(input logic [6:0] f7, input logic [2:0] f3,
                                    input logic [6:0] op);
    instr_u      w;
    logic [31:0] r;
    r           = rand_word();
    w.r.funct7  = f7;
    w.r.rs2     = r[4:0];
    w.r.rs1     = r[9:5];
    w.r.funct3  = f3;
    w.r.rd      = r[14:10];
    w.r.opcode  = op;
    return w;
  endfunction

  function automatic instr_u make_amo(input logic [4:0] f5, input logic [2:0] f3);
    instr_u      w;
    logic [31:0] r;
    r            = rand_word();
    w.amo.funct5 = f5;
    w.amo.aq     = r[15];
    w.amo.rl     = r[16];
    w.amo.rs2    = r[4:0];
    w.amo.rs1    = r[9:5];
    w.amo.funct3 = f3;
    w.amo.rd     = r[14:10];
    w.amo.opcode = OPCODE_AMO;
    return w;
  endfunction

  // Called 2 ns after a rising edge, returns 2 ns after the next one
  task automatic send_instr(input instr_u w, input logic illc);
    instr_valid_i    = 1'b1;
    instr_rdata_i    = w;
    illegal_c_insn_i = illc;
    @(posedge clk);
    #2;
  endtask

  // Junk on the bus while the strobe is low must not reach ctrl_o
  task automatic idle_cycles(input int n);
    repeat (n) begin
      instr_valid_i    = 1'b0;
      instr_rdata_i    = rand_word();
      illegal_c_insn_i = 1'b0;
      @(posedge clk);
      #2;
    end
  endtask

  task automatic close_test(input string name, input int errs_before);
    idle_cycles(2);
    tests_run++;
    if (err_count == errs_before) begin
      $display("[%0t] %s: PASS", $time, name);
    end else begin
      tests_failed++;
      $display("[%0t] %s: FAIL (%0d errors)", $time, name, err_count - errs_before);
    end
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic test_amo();
    logic [4:0] codes [0:10] = '{AMO_LR, AMO_SC, AMO_SWAP, AMO_ADD, AMO_XOR, AMO_AND,
                                 AMO_OR, AMO_MIN, AMO_MAX, AMO_MINU, AMO_MAXU};
    int         base;
    base = err_count;
    foreach (codes[i]) begin
      send_instr(make_amo(codes[i], AMO_WIDTH_W), 1'b0);
    end
    close_test("amo_word_ops", base);
    base = err_count;
    send_instr(make_amo(AMO_ADD, 3'b000), 1'b0);
    send_instr(make_amo(AMO_SWAP, 3'b011), 1'b0);
    send_instr(make_amo(AMO_LR, 3'b001), 1'b0);
    send_instr(make_amo(5'b00101, AMO_WIDTH_W), 1'b0);
    send_instr(make_amo(5'b11111, AMO_WIDTH_W), 1'b0);
    close_test("amo_illegal", base);
  endtask

  task automatic test_muldiv();
    int base;
    base = err_count;
    for (int f = 0; f < 8; f++) begin
      send_instr(make_r(FUNCT7_MULDIV, f[2:0], OPCODE_OP), 1'b0);
    end
    send_instr(make_r(7'b0000010, 3'd0, OPCODE_OP), 1'b0);
    send_instr(make_r(7'b1000000, 3'd5, OPCODE_OP), 1'b0);
    close_test("muldiv_ops", base);
  endtask

  task automatic test_base();
    int base;
    base = err_count;
    for (int f = 0; f < 8; f++) begin
      send_instr(make_r(7'(rand_word()), f[2:0], OPCODE_LOAD), 1'b0);
      send_instr(make_r(7'(rand_word()), f[2:0], OPCODE_STORE), 1'b0);
    end
    close_test("load_store", base);
    base = err_count;
    for (int f = 0; f < 8; f++) begin
      send_instr(make_r(FUNCT7_BASE, f[2:0], OPCODE_OPIMM), 1'b0);
      send_instr(make_r(FUNCT7_BASE, f[2:0], OPCODE_OP), 1'b0);
      send_instr(make_r(FUNCT7_SUB, f[2:0], OPCODE_OP), 1'b0);
    end
    send_instr(make_r(FUNCT7_SUB, 3'd5, OPCODE_OPIMM), 1'b0);
    send_instr(make_r(FUNCT7_SUB, 3'd0, OPCODE_OPIMM), 1'b0);
    send_instr(make_r(FUNCT7_SUB, 3'd1, OPCODE_OPIMM), 1'b0);
    send_instr(make_r(FUNCT7_MULDIV, 3'd5, OPCODE_OPIMM), 1'b0);
    send_instr(make_r(7'(rand_word()), 3'(rand_word()), OPCODE_LUI), 1'b0);
    close_test("alu_and_lui", base);
    base = err_count;
    // Branch, JAL, SYSTEM, FENCE and AUIPC are outside the subset
    send_instr(make_r(FUNCT7_BASE, 3'd0, 7'b1100011), 1'b0);
    send_instr(make_r(FUNCT7_BASE, 3'd0, 7'b1101111), 1'b0);
    send_instr(make_r(FUNCT7_BASE, 3'd0, 7'b1110011), 1'b0);
    send_instr(make_r(FUNCT7_BASE, 3'd0, 7'b0001111), 1'b0);
    send_instr(make_r(FUNCT7_BASE, 3'd0, 7'b0010111), 1'b0);
    close_test("unknown_opcode", base);
  endtask

  task automatic test_illegal_c();
    int base;
    base = err_count;
    send_instr(make_r(FUNCT7_BASE, 3'd0, OPCODE_OP), 1'b1);
    send_instr(make_r(7'(rand_word()), 3'd2, OPCODE_LOAD), 1'b1);
    send_instr(make_r(FUNCT7_MULDIV, 3'd4, OPCODE_OP), 1'b1);
    send_instr(make_amo(AMO_SC, AMO_WIDTH_W), 1'b1);
    close_test("illegal_compressed", base);
  endtask

  task automatic test_pipeline();
    int base;
    base = err_count;
    send_instr(make_r(FUNCT7_BASE, 3'd7, OPCODE_OP), 1'b0);
    idle_cycles(1);
    send_instr(make_amo(AMO_MAX, AMO_WIDTH_W), 1'b0);
    send_instr(make_r(FUNCT7_MULDIV, 3'd1, OPCODE_OP), 1'b0);
    idle_cycles(3);
    send_instr(make_r(7'(rand_word()), 3'd4, OPCODE_LOAD), 1'b0);
    send_instr(make_r(FUNCT7_BASE, 3'd0, 7'b1100011), 1'b0);
    idle_cycles(2);
    send_instr(make_r(7'(rand_word()), 3'd1, OPCODE_STORE), 1'b0);
    close_test("pipeline_gaps", base);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    arst_n_i         = 1'b0;
    instr_valid_i    = 1'b0;
    instr_rdata_i    = '0;
    illegal_c_insn_i = 1'b0;
    repeat (7) @(posedge clk);
    @(negedge clk);
    reset_valid: assert (ctrl_valid_o == 1'b0)
      else begin
        err_count++;
        $display("ERROR t=%0t ctrl_valid_o got 0x%0h expected 0x0", $time, ctrl_valid_o);
      end
    reset_ctrl: assert (ctrl_o == DECODER_CTRL_IDLE)
      else report_ctrl_mismatch(ctrl_o, DECODER_CTRL_IDLE);
    @(posedge clk);
    #2;
    arst_n_i = 1'b1;
    close_test("reset_state", 0);

    test_amo();
    test_muldiv();
    test_base();
    test_illegal_c();
    test_pipeline();

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: sources.f
source/isa_pkg.sv
source/ctrl_pkg.sv
source/i_decoder.sv
source/m_decoder.sv
source/a_decoder.sv
source/decoder.sv
source/id_stage.sv
test/tb_id_stage.sv

// File: Makefile
# Verilator flow for the ID stage testbench
# Any variable can be overridden, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_id_stage
RTL_TOP   ?= id_stage
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=
FAIL_MSG  ?= Simulation failed
PASS_MSG  ?= Simulation passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST) $(VFLAGS)

build:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR) $(VFLAGS)

sim: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Run failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Run ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
